// File: Makefile
SIM  := obj_dir/Vtb_execute_stage
SRCS := $(filter-out +incdir+%,$(shell cat src.f)) dv/exec_model.svh

.PHONY: all run clean

all: run

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module tb_execute_stage

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/exec_model.svh
// reference model of register file, ALU and next-PC rules, included inside the testbench module
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// shadow registers, entry 0 is never written
exec_pkg::word_t model_regs [exec_pkg::NUM_REGS];

function automatic void model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
endfunction

function automatic void model_write(input exec_pkg::reg_idx_t idx, input exec_pkg::word_t data);
    // writes to x0 vanish
    if (idx != '0) begin
        model_regs[idx] = data;
    end
endfunction

function automatic exec_pkg::word_t model_read(input exec_pkg::reg_idx_t idx);
    if (idx == '0) begin
        return '0;
    end
    return model_regs[idx];
endfunction

// replicate bit (bits-1) of v upward
function automatic exec_pkg::word_t sext(input exec_pkg::word_t v, input int bits);
    exec_pkg::word_t up;
    up = v << (32 - bits);
    return $signed(up) >>> (32 - bits);
endfunction

function automatic exec_pkg::word_t model_alu(input exec_pkg::alu_op_t op,
                                              input exec_pkg::word_t a,
                                              input exec_pkg::word_t b);
    logic [4:0]  sh;
    logic [63:0] ext;
    sh  = b[4:0];
    ext = {{32{a[31]}}, a} >> sh;
    case (op)
        exec_pkg::ALU_ADD:  return a + b;
        // two's complement subtract
        exec_pkg::ALU_SUB:  return a + ~b + 32'd1;
        exec_pkg::ALU_AND:  return a & b;
        exec_pkg::ALU_OR:   return a | b;
        exec_pkg::ALU_XOR:  return a ^ b;
        exec_pkg::ALU_SLL:  return a << sh;
        exec_pkg::ALU_SRL:  return a >> sh;
        exec_pkg::ALU_SRA:  return ext[31:0];
        // differing signs decide alone, else unsigned order matches signed
        exec_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
        exec_pkg::ALU_SLTU: return {31'b0, a < b};
        default:            return '0;
    endcase
endfunction

function automatic logic model_taken(input exec_pkg::branch_type_t bt,
                                     input exec_pkg::word_t a,
                                     input exec_pkg::word_t b);
    logic lt_s;
    // flipping the sign bit turns signed order into unsigned order
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (bt)
        exec_pkg::BR_BEQ:  return a == b;
        exec_pkg::BR_BNE:  return a != b;
        exec_pkg::BR_BLT:  return lt_s;
        exec_pkg::BR_BGE:  return !lt_s;
        exec_pkg::BR_BLTU: return a < b;
        exec_pkg::BR_BGEU: return !(a < b);
        default:           return 1'b0;
    endcase
endfunction

function automatic exec_pkg::word_t model_next_pc(input logic jump, input logic j_sel,
                                                  input logic taken, input exec_pkg::word_t pc,
                                                  input exec_pkg::word_t rs1v,
                                                  input exec_pkg::word_t i_ext,
                                                  input exec_pkg::word_t sb_ext,
                                                  input exec_pkg::word_t uj_ext);
    if (jump) begin
        // jal is pc relative, jalr clears bit 0
        return j_sel ? pc + uj_ext : (rs1v + i_ext) & ~32'h1;
    end
    if (taken) begin
        return pc + sb_ext;
    end
    return pc + exec_pkg::word_t'(exec_pkg::PC_STEP);
endfunction

`endif

// File: dv/tb_execute_stage.sv
// self-checking testbench for execute_stage that scores random instructions against an included model
module tb_execute_stage;

    // phase lengths in cycles
    localparam int N_ZERO  = 32;
    localparam int N_FILL  = 64;
    localparam int N_OPSEL = 200;
    localparam int N_FWD   = 200;
    localparam int N_BRJ   = 300;
    localparam int N_CTRL  = 400;
    localparam int TOTAL_CYCLES = N_ZERO + N_FILL + 2 + N_OPSEL + N_FWD + N_BRJ + N_CTRL + 4;
    localparam int WATCHDOG_TIME = (16 + TOTAL_CYCLES + 20) * 4;

    logic CLK = 1'b0;
    logic nRST;
    logic valid, branch, jump, j_sel, reg_write;
    logic fwd_rs1, fwd_rs2, wb_en, stall, flush;
    exec_pkg::word_t        pc, imm_u, fwd_data, wb_data;
    exec_pkg::reg_idx_t     rs1, rs2, rd, wb_rd;
    exec_pkg::imm_i_t       imm_i;
    exec_pkg::imm_s_t       imm_s;
    exec_pkg::imm_sb_t      imm_sb;
    exec_pkg::imm_uj_t      imm_uj;
    exec_pkg::alu_op_t      alu_op;
    exec_pkg::alu_a_sel_t   alu_a_sel;
    exec_pkg::alu_b_sel_t   alu_b_sel;
    exec_pkg::branch_type_t branch_type;
    logic mem_valid, mem_reg_write, mem_jump, mem_branch_taken;
    exec_pkg::reg_idx_t mem_rd;
    exec_pkg::word_t    mem_result, mem_rs2_data, mem_brj_addr, mem_pc4;

    integer seed = 32'hd04b;
    int errors = 0;
    int checks = 0;
    // expected ex/mem register contents
    exec_pkg::ex_mem_t exp_q = '0;

    `include "exec_model.svh"

    execute_stage dut_i (.*);

    always #2 CLK = ~CLK;

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic check_word(input string what, input exec_pkg::word_t got,
                              input exec_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_idx(input string what, input exec_pkg::reg_idx_t got,
                             input exec_pkg::reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // what the register should capture from the inputs applied now
    function automatic exec_pkg::ex_mem_t predict_stage();
        exec_pkg::ex_mem_t p;
        exec_pkg::word_t op1;
        exec_pkg::word_t op2;
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        exec_pkg::word_t i_ext;
        op1   = fwd_rs1 ? fwd_data : model_read(rs1);
        op2   = fwd_rs2 ? fwd_data : model_read(rs2);
        i_ext = sext({20'b0, imm_i}, 12);
        case (alu_a_sel)
            exec_pkg::A_RS1:   a = op1;
            exec_pkg::A_IMM_S: a = sext({20'b0, imm_s}, 12);
            exec_pkg::A_PC:    a = pc;
            default:           a = '0;
        endcase
        case (alu_b_sel)
            exec_pkg::B_RS1:   b = op1;
            exec_pkg::B_RS2:   b = op2;
            exec_pkg::B_IMM_I: b = i_ext;
            default:           b = imm_u;
        endcase
        p.valid        = valid;
        p.rd           = rd;
        p.reg_write    = reg_write;
        p.jump         = jump;
        p.branch_taken = branch && model_taken(branch_type, op1, op2);
        p.result       = model_alu(alu_op, a, b);
        p.rs2_data     = op2;
        p.brj_addr     = model_next_pc(jump, j_sel, p.branch_taken, pc, op1, i_ext,
                                       sext({19'b0, imm_sb}, 13), sext({11'b0, imm_uj}, 21));
        p.pc4          = pc + exec_pkg::word_t'(exec_pkg::PC_STEP);
        return p;
    endfunction

    task automatic compare_outputs();
        check_bit("mem_valid", mem_valid, exp_q.valid);
        check_idx("mem_rd", mem_rd, exp_q.rd);
        check_bit("mem_reg_write", mem_reg_write, exp_q.reg_write);
        check_bit("mem_jump", mem_jump, exp_q.jump);
        check_bit("mem_branch_taken", mem_branch_taken, exp_q.branch_taken);
        check_word("mem_result", mem_result, exp_q.result);
        check_word("mem_rs2_data", mem_rs2_data, exp_q.rs2_data);
        check_word("mem_brj_addr", mem_brj_addr, exp_q.brj_addr);
        check_word("mem_pc4", mem_pc4, exp_q.pc4);
    endtask

    // scoreboard at the falling edge where outputs and inputs have settled
    always @(negedge CLK) begin
        compare_outputs();
        if (!nRST) begin
            exp_q = '0;
            model_reset();
        end else if (!stall) begin
            exp_q = flush ? '0 : predict_stage();
            // read happens before the write lands
            if (wb_en) begin
                model_write(wb_rd, wb_data);
            end
        end
    end

    task automatic drive_defaults();
        valid       <= 1'b0;
        pc          <= '0;
        rs1         <= '0;
        rs2         <= '0;
        rd          <= '0;
        imm_i       <= '0;
        imm_s       <= '0;
        imm_sb      <= '0;
        imm_uj      <= '0;
        imm_u       <= '0;
        alu_op      <= exec_pkg::ALU_ADD;
        alu_a_sel   <= exec_pkg::A_RS1;
        alu_b_sel   <= exec_pkg::B_RS2;
        branch      <= 1'b0;
        branch_type <= exec_pkg::BR_BEQ;
        jump        <= 1'b0;
        j_sel       <= 1'b0;
        reg_write   <= 1'b0;
        fwd_rs1     <= 1'b0;
        fwd_rs2     <= 1'b0;
        fwd_data    <= '0;
        wb_en       <= 1'b0;
        wb_rd       <= '0;
        wb_data     <= '0;
        stall       <= 1'b0;
        flush       <= 1'b0;
    endtask

    // each level adds operand muxes, forwarding, branch/jump and stall/flush in turn
    task automatic drive_random(input int level);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] k;
        drive_defaults();
        r = next_rand();
        valid     <= r[0];
        reg_write <= r[1];
        rd        <= r[6:2];
        rs1       <= r[11:7];
        // equal sources make the equality compares hit
        rs2       <= (level >= 3 && r[12]) ? r[11:7] : r[17:13];
        alu_op    <= exec_pkg::alu_op_t'(4'(r[27:18] % 10));
        alu_b_sel <= r[28] ? exec_pkg::B_RS2 : exec_pkg::B_RS1;
        wb_en     <= r[29];
        s = next_rand();
        wb_rd     <= s[4:0];
        wb_data   <= next_rand();
        if (level >= 1) begin
            r = next_rand();
            s = next_rand();
            alu_a_sel <= exec_pkg::alu_a_sel_t'(r[1:0]);
            alu_b_sel <= exec_pkg::alu_b_sel_t'(r[3:2]);
            imm_i     <= r[15:4];
            imm_s     <= r[27:16];
            imm_sb    <= s[12:0];
            imm_uj    <= s[31:11];
            imm_u     <= next_rand();
            pc        <= next_rand();
        end
        if (level >= 2) begin
            r = next_rand();
            fwd_rs1  <= r[0];
            fwd_rs2  <= r[1];
            fwd_data <= next_rand();
        end
        if (level >= 3) begin
            r = next_rand();
            k = r[31:8] % 6;
            branch      <= r[0];
            jump        <= r[2:1] == 2'b00;
            j_sel       <= r[3];
            // six legal codes skip 010 and 011
            branch_type <= exec_pkg::branch_type_t'(3'(k < 2 ? k : k + 2));
        end
        if (level >= 4) begin
            r = next_rand();
            stall <= r[1:0] == 2'b00;
            flush <= r[4:2] == 3'b000;
        end
    endtask

    task automatic run_random(input int level, input int cycles);
        repeat (cycles) begin
            @(posedge CLK);
            drive_random(level);
        end
    endtask

    initial begin
        nRST = 1'b0;
        drive_defaults();
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        // every register reads zero out of reset
        for (int i = 0; i < N_ZERO; i++) begin
            @(posedge CLK);
            drive_defaults();
            valid     <= 1'b1;
            rs1       <= exec_pkg::reg_idx_t'(i);
            rs2       <= exec_pkg::reg_idx_t'(i);
            alu_a_sel <= exec_pkg::A_ZERO;
            alu_b_sel <= i[0] ? exec_pkg::B_RS2 : exec_pkg::B_RS1;
        end
        // fill x1..x31 first and then random targets
        for (int i = 0; i < N_FILL; i++) begin
            @(posedge CLK);
            drive_random(0);
            wb_en <= 1'b1;
            if (i < 31) begin
                wb_rd <= exec_pkg::reg_idx_t'(i + 1);
            end
        end
        // write x0 then read it back
        @(posedge CLK);
        drive_defaults();
        wb_en   <= 1'b1;
        wb_rd   <= '0;
        wb_data <= 32'hdead_beef;
        @(posedge CLK);
        drive_defaults();
        valid  <= 1'b1;
        alu_op <= exec_pkg::ALU_OR;
        run_random(1, N_OPSEL);
        run_random(2, N_FWD);
        run_random(3, N_BRJ);
        run_random(4, N_CTRL);
        @(posedge CLK);
        drive_defaults();
        // drain the last captured instruction
        repeat (3) @(posedge CLK);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: stimulus did not finish within %0d time units", WATCHDOG_TIME);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: hw/alu.sv
// integer ALU for the RV32I base operations, purely combinational
module alu (
    exec_operand_if.alu_side   ops,
    input  exec_pkg::alu_op_t  alu_op,
    output exec_pkg::word_t    result
);

    logic [4:0] shamt;

    // only five bits matter for a 32-bit shift
    assign shamt = ops.alu_b[4:0];

    always_comb begin
        case (alu_op)
            exec_pkg::ALU_ADD:  result = ops.alu_a + ops.alu_b;
            exec_pkg::ALU_SUB:  result = ops.alu_a - ops.alu_b;
            exec_pkg::ALU_AND:  result = ops.alu_a & ops.alu_b;
            exec_pkg::ALU_OR:   result = ops.alu_a | ops.alu_b;
            exec_pkg::ALU_XOR:  result = ops.alu_a ^ ops.alu_b;
            exec_pkg::ALU_SLL:  result = ops.alu_a << shamt;
            exec_pkg::ALU_SRL:  result = ops.alu_a >> shamt;
            // arithmetic shift keeps the sign bit
            exec_pkg::ALU_SRA:  result = $signed(ops.alu_a) >>> shamt;
            exec_pkg::ALU_SLT:  result = {31'b0, $signed(ops.alu_a) < $signed(ops.alu_b)};
            exec_pkg::ALU_SLTU: result = {31'b0, ops.alu_a < ops.alu_b};
            default:            result = '0;
        endcase
    end

    // decoder must never hand over one of the six unused codes
    always_comb begin
        if (!$isunknown(alu_op)) begin
            a_alu_op_legal : assert (alu_op inside {
                exec_pkg::ALU_ADD, exec_pkg::ALU_SUB, exec_pkg::ALU_AND, exec_pkg::ALU_OR,
                exec_pkg::ALU_XOR, exec_pkg::ALU_SLL, exec_pkg::ALU_SRL, exec_pkg::ALU_SRA,
                exec_pkg::ALU_SLT, exec_pkg::ALU_SLTU})
            else $error("undefined ALU operation code");
        end
    end

endmodule

// File: hw/branch_jump_unit.sv
// branch compare, branch/jal/jalr targets and next-PC address selection
module branch_jump_unit (
    exec_operand_if.bju_side       ops,
    input  logic                   branch,
    input  logic                   jump,
    input  logic                   j_sel,
    input  exec_pkg::branch_type_t branch_type,
    output logic                   branch_taken,
    output exec_pkg::word_t        brj_addr,
    output exec_pkg::word_t        pc4
);

    logic            cmp;
    exec_pkg::word_t branch_target;
    exec_pkg::word_t jal_target;
    exec_pkg::word_t jalr_sum;
    exec_pkg::word_t jalr_target;
    exec_pkg::word_t jump_target;

    // compare on the forwarded operands
    always_comb begin
        case (branch_type)
            exec_pkg::BR_BEQ:  cmp = ops.rs1_val == ops.rs2_val;
            exec_pkg::BR_BNE:  cmp = ops.rs1_val != ops.rs2_val;
            exec_pkg::BR_BLT:  cmp = $signed(ops.rs1_val) < $signed(ops.rs2_val);
            exec_pkg::BR_BGE:  cmp = $signed(ops.rs1_val) >= $signed(ops.rs2_val);
            exec_pkg::BR_BLTU: cmp = ops.rs1_val < ops.rs2_val;
            exec_pkg::BR_BGEU: cmp = ops.rs1_val >= ops.rs2_val;
            default:           cmp = 1'b0;
        endcase
    end

    assign branch_taken = branch && cmp;

    // candidate targets
    assign pc4           = ops.pc + exec_pkg::word_t'(exec_pkg::PC_STEP);
    assign branch_target = ops.pc + ops.imm_sb_ext;
    assign jal_target    = ops.pc + ops.imm_uj_ext;
    assign jalr_sum      = ops.rs1_val + ops.imm_i_ext;
    // jalr drops bit 0 of the sum
    assign jalr_target   = {jalr_sum[31:1], 1'b0};
    assign jump_target   = j_sel ? jal_target : jalr_target;

    // jump first, then taken branch, else fall through
    always_comb begin
        if (jump) begin
            brj_addr = jump_target;
        end else if (branch_taken) begin
            brj_addr = branch_target;
        end else begin
            brj_addr = pc4;
        end
    end

endmodule

// File: hw/ex_mem_reg.sv
// execute/memory pipeline register that holds under stall and clears on flush
module ex_mem_reg (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              stall,
    input  logic              flush,
    input  exec_pkg::ex_mem_t d,
    output exec_pkg::ex_mem_t q
);

    exec_pkg::ex_mem_t q_r;

    // stall has priority over flush
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            q_r <= '0;
        end else if (!stall) begin
            if (flush) begin
                // bubble with every field zero
                q_r <= '0;
            end else begin
                q_r <= d;
            end
        end
    end

    assign q = q_r;

    // a stalled edge must not move any field even under flush
    a_stall_holds : assert property (
        @(posedge CLK) disable iff (!nRST)
        stall |=> $stable(q)
    ) else $error("ex/mem register changed across a stalled edge");

endmodule

// File: hw/exec_operand_if.sv
// bundle of forwarded operands, pc and extended immediates fed to the ALU and branch unit
interface exec_operand_if;

    // forwarded register operands
    exec_pkg::word_t rs1_val;
    exec_pkg::word_t rs2_val;
    exec_pkg::word_t pc;
    // sign extended immediates
    exec_pkg::word_t imm_i_ext;
    exec_pkg::word_t imm_sb_ext;
    exec_pkg::word_t imm_uj_ext;
    // selected ALU ports
    exec_pkg::word_t alu_a;
    exec_pkg::word_t alu_b;

    modport src (output rs1_val, rs2_val, pc, imm_i_ext, imm_sb_ext, imm_uj_ext, alu_a, alu_b);
    modport alu_side (input alu_a, alu_b);
    modport bju_side (input rs1_val, rs2_val, pc, imm_i_ext, imm_sb_ext, imm_uj_ext);

endinterface

// File: hw/exec_pkg.sv
// shared widths, enums and the execute/memory register layout, referenced by scoped names
package exec_pkg;

    // datapath basics
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int unsigned NUM_REGS = 32;
    // sequential fetch increment
    localparam int unsigned PC_STEP = 4;

    // raw immediate fields as the decoder hands them over
    typedef logic [11:0] imm_i_t;
    typedef logic [11:0] imm_s_t;
    typedef logic [12:0] imm_sb_t;
    typedef logic [20:0] imm_uj_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    typedef enum logic [1:0] {A_RS1, A_IMM_S, A_PC, A_ZERO} alu_a_sel_t;
    typedef enum logic [1:0] {B_RS1, B_RS2, B_IMM_I, B_IMM_U} alu_b_sel_t;

    // same encoding as funct3 of the branch opcodes
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_type_t;

    // execute/memory register contents, 137 bits
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        logic     jump;
        logic     branch_taken;
        word_t    result;
        word_t    rs2_data;
        word_t    brj_addr;
        word_t    pc4;
    } ex_mem_t;

endpackage

// File: hw/execute_stage.sv
// execute stage top, plain decoded-instruction ports in and registered mem_* results out
module execute_stage (
    input  logic                   CLK,
    input  logic                   nRST,
    // decoded instruction
    input  logic                   valid,
    input  exec_pkg::word_t        pc,
    input  exec_pkg::reg_idx_t     rs1,
    input  exec_pkg::reg_idx_t     rs2,
    input  exec_pkg::reg_idx_t     rd,
    input  exec_pkg::imm_i_t       imm_i,
    input  exec_pkg::imm_s_t       imm_s,
    input  exec_pkg::imm_sb_t      imm_sb,
    input  exec_pkg::imm_uj_t      imm_uj,
    input  exec_pkg::word_t        imm_u,
    input  exec_pkg::alu_op_t      alu_op,
    input  exec_pkg::alu_a_sel_t   alu_a_sel,
    input  exec_pkg::alu_b_sel_t   alu_b_sel,
    input  logic                   branch,
    input  exec_pkg::branch_type_t branch_type,
    input  logic                   jump,
    input  logic                   j_sel,
    input  logic                   reg_write,
    // forwarding from memory stage
    input  logic                   fwd_rs1,
    input  logic                   fwd_rs2,
    input  exec_pkg::word_t        fwd_data,
    // writeback
    input  logic                   wb_en,
    input  exec_pkg::reg_idx_t     wb_rd,
    input  exec_pkg::word_t        wb_data,
    // pipeline control
    input  logic                   stall,
    input  logic                   flush,
    output logic                   mem_valid,
    output exec_pkg::reg_idx_t     mem_rd,
    output logic                   mem_reg_write,
    output logic                   mem_jump,
    output logic                   mem_branch_taken,
    output exec_pkg::word_t        mem_result,
    output exec_pkg::word_t        mem_rs2_data,
    output exec_pkg::word_t        mem_brj_addr,
    output exec_pkg::word_t        mem_pc4
);

    logic              rf_wr_en;
    logic              branch_taken;
    exec_pkg::word_t   rs1_data;
    exec_pkg::word_t   rs2_data;
    exec_pkg::word_t   alu_result;
    exec_pkg::word_t   brj_addr;
    exec_pkg::word_t   pc4;
    exec_pkg::ex_mem_t d;
    exec_pkg::ex_mem_t q;

    exec_operand_if ops ();

    // writeback is suppressed while the pipe is stalled
    assign rf_wr_en = wb_en && !stall;

    reg_file rf_i (
        .CLK, .nRST, .rs1, .rs2,
        .wr_rd(wb_rd), .wr_en(rf_wr_en), .wr_data(wb_data),
        .rs1_data, .rs2_data
    );

    operand_select opsel_i (
        .rs1_data, .rs2_data, .fwd_data, .pc, .fwd_rs1, .fwd_rs2,
        .imm_i, .imm_s, .imm_sb, .imm_uj, .imm_u, .alu_a_sel, .alu_b_sel,
        .ops(ops.src)
    );

    alu alu_i (.ops(ops.alu_side), .alu_op, .result(alu_result));

    branch_jump_unit bju_i (
        .ops(ops.bju_side), .branch, .jump, .j_sel, .branch_type,
        .branch_taken, .brj_addr, .pc4
    );

    // pack next register contents, store data is the forwarded rs2
    assign d.valid        = valid;
    assign d.rd           = rd;
    assign d.reg_write    = reg_write;
    assign d.jump         = jump;
    assign d.branch_taken = branch_taken;
    assign d.result       = alu_result;
    assign d.rs2_data     = ops.rs2_val;
    assign d.brj_addr     = brj_addr;
    assign d.pc4          = pc4;

    ex_mem_reg pipe_i (.CLK, .nRST, .stall, .flush, .d, .q);

    // unpack onto the memory stage ports
    assign mem_valid        = q.valid;
    assign mem_rd           = q.rd;
    assign mem_reg_write    = q.reg_write;
    assign mem_jump         = q.jump;
    assign mem_branch_taken = q.branch_taken;
    assign mem_result       = q.result;
    assign mem_rs2_data     = q.rs2_data;
    assign mem_brj_addr     = q.brj_addr;
    assign mem_pc4          = q.pc4;

endmodule

// File: hw/operand_select.sv
// forwarding, immediate sign extension and ALU operand muxing for the execute stage
module operand_select (
    input  exec_pkg::word_t      rs1_data,
    input  exec_pkg::word_t      rs2_data,
    input  exec_pkg::word_t      fwd_data,
    input  exec_pkg::word_t      pc,
    input  logic                 fwd_rs1,
    input  logic                 fwd_rs2,
    input  exec_pkg::imm_i_t     imm_i,
    input  exec_pkg::imm_s_t     imm_s,
    input  exec_pkg::imm_sb_t    imm_sb,
    input  exec_pkg::imm_uj_t    imm_uj,
    input  exec_pkg::word_t      imm_u,
    input  exec_pkg::alu_a_sel_t alu_a_sel,
    input  exec_pkg::alu_b_sel_t alu_b_sel,
    exec_operand_if.src          ops
);

    // S immediate only feeds port A, never leaves this block
    exec_pkg::word_t imm_s_ext;

    // memory stage result overrides the register read
    assign ops.rs1_val = fwd_rs1 ? fwd_data : rs1_data;
    assign ops.rs2_val = fwd_rs2 ? fwd_data : rs2_data;
    assign ops.pc      = pc;

    // sign extension to word width
    assign ops.imm_i_ext  = {{20{imm_i[11]}}, imm_i};
    assign imm_s_ext      = {{20{imm_s[11]}}, imm_s};
    assign ops.imm_sb_ext = {{19{imm_sb[12]}}, imm_sb};
    assign ops.imm_uj_ext = {{11{imm_uj[20]}}, imm_uj};

    // port A
    always_comb begin
        case (alu_a_sel)
            exec_pkg::A_RS1:   ops.alu_a = ops.rs1_val;
            exec_pkg::A_IMM_S: ops.alu_a = imm_s_ext;
            exec_pkg::A_PC:    ops.alu_a = pc;
            default:           ops.alu_a = '0;
        endcase
    end

    // port B, shifts take their amount from the low bits of the I immediate
    always_comb begin
        case (alu_b_sel)
            exec_pkg::B_RS1:   ops.alu_b = ops.rs1_val;
            exec_pkg::B_RS2:   ops.alu_b = ops.rs2_val;
            exec_pkg::B_IMM_I: ops.alu_b = ops.imm_i_ext;
            default:           ops.alu_b = imm_u;
        endcase
    end

endmodule

// File: hw/reg_file.sv
// integer register file with two combinational reads and one clocked writeback port
module reg_file (
    input  logic              CLK,
    input  logic              nRST,
    input  exec_pkg::reg_idx_t rs1,
    input  exec_pkg::reg_idx_t rs2,
    input  exec_pkg::reg_idx_t wr_rd,
    input  logic              wr_en,
    input  exec_pkg::word_t   wr_data,
    output exec_pkg::word_t   rs1_data,
    output exec_pkg::word_t   rs2_data
);

    // x1..x31 only, x0 has no storage
    exec_pkg::word_t [exec_pkg::NUM_REGS-1:1] regs;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '0;
        end else if (wr_en && wr_rd != '0) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // no bypass, a write shows up on the next cycle
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // a write aimed at x0 must leave every stored register untouched
    a_no_x0_write : assert property (
        @(posedge CLK) disable iff (!nRST)
        (wr_en && wr_rd == '0) |=> $stable(regs)
    ) else $error("write to x0 changed register storage");

endmodule

// File: src.f
+incdir+dv
hw/exec_pkg.sv
hw/exec_operand_if.sv
hw/reg_file.sv
hw/operand_select.sv
hw/alu.sv
hw/branch_jump_unit.sv
hw/ex_mem_reg.sv
hw/execute_stage.sv
dv/tb_execute_stage.sv
